/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := mem_system_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/cache_arbiter.sv */
/*
  Shares the single memory port between data side and icache.
  The data side wins whenever its command is not bus_none.
  Icache requests always go out as double-size loads.
*/
`default_nettype none

module cache_arbiter (
    // Data side request, held as levels
    input  mem_pkg::bus_command_t              dcache2mem_command,
    input  wire  [mem_pkg::xlen-1:0]           dcache2mem_addr,
    input  mem_pkg::mem_size_t                 dcache2mem_size,
    input  wire  [mem_pkg::mem_data_w-1:0]     dcache2mem_data,

    // Icache miss request
    input  mem_pkg::bus_command_t              icache2mem_command,
    input  wire  [mem_pkg::xlen-1:0]           icache2mem_addr,

    // Memory port
    output mem_pkg::bus_command_t              cache2mem_command,
    output logic [mem_pkg::xlen-1:0]           cache2mem_addr,
    output mem_pkg::mem_size_t                 cache2mem_size,
    output logic [mem_pkg::mem_data_w-1:0]     cache2mem_data,

    output logic                               grant_dcache  // To the router
);

    import mem_pkg::*;

    ////////////////////////////////////////////////////////////
    // Grant
    ////////////////////////////////////////////////////////////

    // Fixed priority, data side first
    assign grant_dcache = (dcache2mem_command != bus_none);

    ////////////////////////////////////////////////////////////
    // Port mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (grant_dcache) begin
            cache2mem_command = dcache2mem_command;
            cache2mem_addr    = dcache2mem_addr;
            cache2mem_size    = dcache2mem_size;
            cache2mem_data    = dcache2mem_data;
        end else begin
            // Icache only ever reads whole blocks
            cache2mem_command = icache2mem_command;
            cache2mem_addr    = icache2mem_addr;
            cache2mem_size    = double_sz;
            cache2mem_data    = '0;
        end
    end

endmodule : cache_arbiter

`default_nettype wire

/* source/icache.sv */
/*
  Blocking direct-mapped instruction cache, one miss outstanding.
  A hit is reported in the same cycle as the fetch address.
  A miss holds its load until memory accepts it; the line fills on the tag reply.
*/
`default_nettype none

module icache (
    input  wire                              clock,
    input  wire                              rst_n,
    input  wire  [mem_pkg::xlen-1:0]         proc2icache_addr,
    input  wire  [mem_pkg::tag_w-1:0]        mem2icache_response,
    input  wire  [mem_pkg::mem_data_w-1:0]   mem2icache_data,
    input  wire  [mem_pkg::tag_w-1:0]        mem2icache_tag,
    output logic [mem_pkg::inst_w-1:0]       icache2proc_data,
    output logic                             icache2proc_valid,
    output mem_pkg::bus_command_t            icache2mem_command,
    output logic [mem_pkg::xlen-1:0]         icache2mem_addr
);

    import mem_pkg::*;

    ////////////////////////////////////////////////////////////
    // Line arrays
    ////////////////////////////////////////////////////////////

    logic [mem_data_w-1:0]   data_mem [icache_lines];
    logic [icache_tag_w-1:0] tag_mem  [icache_lines];
    logic [icache_lines-1:0] line_valid;

    // Outstanding miss
    logic                      miss_pending;
    logic [tag_w-1:0]          pending_tag;   // Tag memory gave the load
    logic [icache_index_w-1:0] fill_index;    // Line to fill on reply
    logic [icache_tag_w-1:0]   fill_tag;

    logic [icache_index_w-1:0] cur_index;
    logic [icache_tag_w-1:0]   cur_tag;
    logic [mem_data_w-1:0]     cur_block;
    logic                      hit;
    logic                      miss_request;
    logic                      req_accepted;
    logic                      fill_now;

    assign cur_index = proc2icache_addr[block_offset_w +: icache_index_w];
    assign cur_tag   = proc2icache_addr[xlen-1 -: icache_tag_w];
    assign cur_block = data_mem[cur_index];

    assign hit = line_valid[cur_index] && (tag_mem[cur_index] == cur_tag);

    // Address bit 2 picks the word inside the block
    assign icache2proc_data  = proc2icache_addr[block_offset_w-1] ?
                               cur_block[mem_data_w-1 -: inst_w] :
                               cur_block[inst_w-1:0];
    assign icache2proc_valid = hit;

    ////////////////////////////////////////////////////////////
    // Miss request
    ////////////////////////////////////////////////////////////

    assign miss_request = !hit && !miss_pending;   // Blocking, one at a time
    assign req_accepted = miss_request && (mem2icache_response != '0);
    assign fill_now     = miss_pending && (mem2icache_tag == pending_tag);

    assign icache2mem_command = miss_request ? bus_load : bus_none;
    assign icache2mem_addr    = {proc2icache_addr[xlen-1:block_offset_w],
                                 {block_offset_w{1'b0}}};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            line_valid   <= '0;
            miss_pending <= 1'b0;
            pending_tag  <= '0;
        end else begin
            if (fill_now) begin
                line_valid[fill_index] <= 1'b1;   // Usable from next cycle
                miss_pending           <= 1'b0;
            end else if (req_accepted) begin
                miss_pending <= 1'b1;
                pending_tag  <= mem2icache_response;
            end
        end
    end

    // Fill target is captured at accept time, so a moved fetch address
    // still fills the line that was asked for
    always_ff @(posedge clock) begin
        if (req_accepted) begin
            fill_index <= cur_index;
            fill_tag   <= cur_tag;
        end
        if (fill_now) begin
            data_mem[fill_index] <= mem2icache_data;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

endmodule : icache

`default_nettype wire

/* source/mem_pkg.sv */
/*
  Shared widths, encodings and cache geometry for the memory side.
  Memory tags are 4 bits and tag zero always means no tag.
  The icache geometry assumes 8-byte blocks and a 32-bit address.
*/
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    localparam int xlen       = 32;  // Address width
    localparam int mem_data_w = 64;  // One memory block per beat
    localparam int tag_w      = 4;   // Memory tag, zero is none
    localparam int num_tags   = 16;  // Every tag value, owner table size
    localparam int inst_w     = 32;  // Word returned to fetch

    ////////////////////////////////////////////////////////////
    // Bus encodings
    ////////////////////////////////////////////////////////////

    // Memory port command
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // Access size on the memory port
    typedef enum logic [1:0] {
        byte_sz   = 2'h0,
        half_sz   = 2'h1,
        word_sz   = 2'h2,
        double_sz = 2'h3
    } mem_size_t;

    ////////////////////////////////////////////////////////////
    // Instruction cache geometry
    ////////////////////////////////////////////////////////////

    localparam int icache_lines   = 32;
    localparam int icache_index_w = 5;   // Address bits 7:3
    localparam int block_offset_w = 3;   // 8-byte blocks

    // Remaining upper address bits
    localparam int icache_tag_w = xlen - icache_index_w - block_offset_w;

endpackage : mem_pkg

`default_nettype wire

/* source/mem_resp_router.sv */
/*
  Steers memory responses and replies back to the cache that asked.
  Only loads enter the owner table; store tags get no reply.
  A reply whose tag has no pending entry is dropped.
*/
`default_nettype none

module mem_resp_router (
    input  wire                                clock,
    input  wire                                rst_n,
    input  wire                                grant_dcache,
    input  mem_pkg::bus_command_t              cache2mem_command,

    // From memory
    input  wire  [mem_pkg::tag_w-1:0]          mem2cache_response,
    input  wire  [mem_pkg::mem_data_w-1:0]     mem2cache_data,
    input  wire  [mem_pkg::tag_w-1:0]          mem2cache_tag,

    // To the icache
    output logic [mem_pkg::tag_w-1:0]          mem2icache_response,
    output logic [mem_pkg::mem_data_w-1:0]     mem2icache_data,
    output logic [mem_pkg::tag_w-1:0]          mem2icache_tag,

    // To the data side
    output logic [mem_pkg::tag_w-1:0]          mem2dcache_response,
    output logic [mem_pkg::mem_data_w-1:0]     mem2dcache_data,
    output logic [mem_pkg::tag_w-1:0]          mem2dcache_tag,
    output logic                               mem2dcache_response_valid
);

    import mem_pkg::*;

    logic [num_tags-1:0] tag_pending;    // Load reply still expected
    logic [num_tags-1:0] owner_dcache;   // 1 data side, 0 icache

    logic load_accepted;
    logic reply_hit;
    logic reply_dcache;

    ////////////////////////////////////////////////////////////
    // Accept response
    ////////////////////////////////////////////////////////////

    // Only the granted side sees the tag
    assign mem2dcache_response = grant_dcache ? mem2cache_response : '0;
    assign mem2icache_response = grant_dcache ? '0 : mem2cache_response;

    assign mem2dcache_response_valid = grant_dcache && (mem2cache_response != '0);

    assign load_accepted = (cache2mem_command == bus_load) && (mem2cache_response != '0);

    ////////////////////////////////////////////////////////////
    // Reply steering
    ////////////////////////////////////////////////////////////

    assign reply_hit    = (mem2cache_tag != '0) && tag_pending[mem2cache_tag];
    assign reply_dcache = owner_dcache[mem2cache_tag];

    always_comb begin
        mem2icache_data = '0;
        mem2icache_tag  = '0;
        mem2dcache_data = '0;
        mem2dcache_tag  = '0;
        if (reply_hit) begin
            if (reply_dcache) begin
                mem2dcache_data = mem2cache_data;
                mem2dcache_tag  = mem2cache_tag;
            end else begin
                mem2icache_data = mem2cache_data;
                mem2icache_tag  = mem2cache_tag;
            end
        end
    end

    // Pending bits; a tag reissued in its reply cycle stays pending
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            tag_pending <= '0;
        end else begin
            if (reply_hit)
                tag_pending[mem2cache_tag] <= 1'b0;
            if (load_accepted)
                tag_pending[mem2cache_response] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (load_accepted)
            owner_dcache[mem2cache_response] <= grant_dcache;
    end

endmodule : mem_resp_router

`default_nettype wire

/* source/mem_system.sv */
/*
  Memory side of the processor: icache, arbiter and reply routing.
  Data-side requests and replies are top-level ports, there is no data cache.
*/
`default_nettype none

module mem_system (
    input  wire                                clock,
    input  wire                                rst_n,

    // Fetch side
    input  wire  [mem_pkg::xlen-1:0]           proc2icache_addr,
    output logic [mem_pkg::inst_w-1:0]         icache2proc_data,
    output logic                               icache2proc_valid,

    // Data side
    input  mem_pkg::bus_command_t              dcache2mem_command,
    input  wire  [mem_pkg::xlen-1:0]           dcache2mem_addr,
    input  mem_pkg::mem_size_t                 dcache2mem_size,
    input  wire  [mem_pkg::mem_data_w-1:0]     dcache2mem_data,
    output logic [mem_pkg::tag_w-1:0]          mem2dcache_response,
    output logic [mem_pkg::mem_data_w-1:0]     mem2dcache_data,
    output logic [mem_pkg::tag_w-1:0]          mem2dcache_tag,
    output logic                               mem2dcache_response_valid,

    // Memory port
    output mem_pkg::bus_command_t              cache2mem_command,
    output logic [mem_pkg::xlen-1:0]           cache2mem_addr,
    output mem_pkg::mem_size_t                 cache2mem_size,
    output logic [mem_pkg::mem_data_w-1:0]     cache2mem_data,
    input  wire  [mem_pkg::tag_w-1:0]          mem2cache_response,
    input  wire  [mem_pkg::mem_data_w-1:0]     mem2cache_data,
    input  wire  [mem_pkg::tag_w-1:0]          mem2cache_tag
);

    import mem_pkg::*;

    bus_command_t          icache2mem_command;
    logic [xlen-1:0]       icache2mem_addr;
    logic [tag_w-1:0]      mem2icache_response;
    logic [mem_data_w-1:0] mem2icache_data;
    logic [tag_w-1:0]      mem2icache_tag;
    logic                  grant_dcache;

    ////////////////////////////////////////////////////////////
    // Instruction cache
    ////////////////////////////////////////////////////////////

    icache icache0 (
        .clock               (clock),
        .rst_n               (rst_n),
        .proc2icache_addr    (proc2icache_addr),
        .mem2icache_response (mem2icache_response),
        .mem2icache_data     (mem2icache_data),
        .mem2icache_tag      (mem2icache_tag),
        .icache2proc_data    (icache2proc_data),
        .icache2proc_valid   (icache2proc_valid),
        .icache2mem_command  (icache2mem_command),
        .icache2mem_addr     (icache2mem_addr)
    );

    ////////////////////////////////////////////////////////////
    // Arbiter and reply routing
    ////////////////////////////////////////////////////////////

    cache_arbiter cache_arbiter0 (
        .dcache2mem_command (dcache2mem_command),
        .dcache2mem_addr    (dcache2mem_addr),
        .dcache2mem_size    (dcache2mem_size),
        .dcache2mem_data    (dcache2mem_data),
        .icache2mem_command (icache2mem_command),
        .icache2mem_addr    (icache2mem_addr),
        .cache2mem_command  (cache2mem_command),
        .cache2mem_addr     (cache2mem_addr),
        .cache2mem_size     (cache2mem_size),
        .cache2mem_data     (cache2mem_data),
        .grant_dcache       (grant_dcache)
    );

    mem_resp_router mem_resp_router0 (
        .clock                     (clock),
        .rst_n                     (rst_n),
        .grant_dcache              (grant_dcache),
        .cache2mem_command         (cache2mem_command),   // Only loads get owners
        .mem2cache_response        (mem2cache_response),
        .mem2cache_data            (mem2cache_data),
        .mem2cache_tag             (mem2cache_tag),
        .mem2icache_response       (mem2icache_response),
        .mem2icache_data           (mem2icache_data),
        .mem2icache_tag            (mem2icache_tag),
        .mem2dcache_response       (mem2dcache_response),
        .mem2dcache_data           (mem2dcache_data),
        .mem2dcache_tag            (mem2dcache_tag),
        .mem2dcache_response_valid (mem2dcache_response_valid)
    );

endmodule : mem_system

`default_nettype wire

/* src.f */
source/mem_pkg.sv
source/icache.sv
source/cache_arbiter.sv
source/mem_resp_router.sv
source/mem_system.sv
verif/mem_system_asserts.sv
verif/mem_system_tb.sv

/* verif/mem_system_asserts.sv */
/*
  Concurrent checks on arbitration and reply routing, bound into the top.
  Checks are off while reset is low, except the fetch valid check.
*/
`default_nettype none

module mem_system_asserts (
    input wire                           clock,
    input wire                           rst_n,
    input mem_pkg::bus_command_t         dcache2mem_command,
    input wire  [mem_pkg::xlen-1:0]      dcache2mem_addr,
    input wire  [mem_pkg::xlen-1:0]      cache2mem_addr,
    input wire                           icache2proc_valid,
    input wire  [mem_pkg::tag_w-1:0]     mem2icache_tag,
    input wire  [mem_pkg::tag_w-1:0]     mem2dcache_tag
);

    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    ////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////

    // Data side owns the port whenever it asks
    data_addr_on_port: assert property (@(posedge clock) disable iff (!rst_n)
        (dcache2mem_command != bus_none) |-> (cache2mem_addr == dcache2mem_addr))
        else $error("Memory port address is not the data request address");

    // Line valid bits clear on the reset edge
    no_valid_in_reset: assert property (@(posedge clock)
        !rst_n |=> !icache2proc_valid)
        else $error("Fetch valid seen during reset");

    ////////////////////////////////////////////////////////////
    // Reply routing
    ////////////////////////////////////////////////////////////

    one_reply_owner: assert property (@(posedge clock) disable iff (!rst_n)
        (mem2icache_tag != '0) |-> (mem2dcache_tag == '0))
        else $error("Reply tag steered to both caches");

endmodule : mem_system_asserts

`default_nettype wire

/* verif/mem_system_tb.sv */
/*
  Drives the memory side from a table of fetch and data requests.
  The memory model accepts at random, hands out rotating tags 1 to 15
  and replies to loads after 1 to 6 cycles. Stores get a tag and no reply.
*/
`default_nettype none

module mem_system_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int wait_limit = 200;   // Cycles per wait loop

    typedef struct packed {
        logic [xlen-1:0]   fetch_addr;
        bus_command_t      data_cmd;
        logic [xlen-1:0]   data_addr;
        logic [inst_w-1:0] exp_word;
        logic              exp_hit;    // Fetch hits in its first cycle
    } entry_t;

    logic                  clock = 1'b0;
    logic                  rst_n;
    logic [xlen-1:0]       proc2icache_addr;
    logic [inst_w-1:0]     icache2proc_data;
    logic                  icache2proc_valid;
    bus_command_t          dcache2mem_command;
    logic [xlen-1:0]       dcache2mem_addr;
    mem_size_t             dcache2mem_size;
    logic [mem_data_w-1:0] dcache2mem_data;
    logic [tag_w-1:0]      mem2dcache_response;
    logic [mem_data_w-1:0] mem2dcache_data;
    logic [tag_w-1:0]      mem2dcache_tag;
    logic                  mem2dcache_response_valid;
    bus_command_t          cache2mem_command;
    logic [xlen-1:0]       cache2mem_addr;
    mem_size_t             cache2mem_size;
    logic [mem_data_w-1:0] cache2mem_data;
    logic [tag_w-1:0]      mem2cache_response = '0;
    logic [mem_data_w-1:0] mem2cache_data = '0;
    logic [tag_w-1:0]      mem2cache_tag = '0;

    // Memory model state
    logic [tag_w-1:0] next_tag = 4'd1;
    int               cycle = 0;
    int               reply_idx;
    logic [tag_w-1:0] reply_tag_q [$];
    logic [xlen-1:0]  reply_addr_q [$];
    int               reply_due_q [$];

    entry_t tests [$];
    int     errors = 0;
    int     test_errors;
    int     tests_failed = 0;

    always #2 clock = ~clock;

    mem_system dut0 (.*);

    bind mem_system mem_system_asserts asserts0 (
        .clock              (clock),
        .rst_n              (rst_n),
        .dcache2mem_command (dcache2mem_command),
        .dcache2mem_addr    (dcache2mem_addr),
        .cache2mem_addr     (cache2mem_addr),
        .icache2proc_valid  (icache2proc_valid),
        .mem2icache_tag     (mem2icache_tag),
        .mem2dcache_tag     (mem2dcache_tag)
    );

    ////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////

    // Low word is the block address, high word is it xor 5a5a5a5a
    function automatic logic [mem_data_w-1:0] block_data(input logic [xlen-1:0] block);
        return {block ^ 32'h5a5a5a5a, block};
    endfunction

    initial begin
        void'($urandom(32'hfa112f23));
        forever begin
            @(posedge clock);
            if (!rst_n) begin
                mem2cache_response <= '0;
                mem2cache_tag      <= '0;
                mem2cache_data     <= '0;
                next_tag           <= 4'd1;
                reply_tag_q.delete();
                reply_addr_q.delete();
                reply_due_q.delete();
            end else begin
                cycle = cycle + 1;
                if (mem2cache_response != '0 && cache2mem_command != bus_none) begin
                    if (cache2mem_command == bus_load) begin   // Stores get no reply
                        reply_tag_q.push_back(mem2cache_response);
                        reply_addr_q.push_back(cache2mem_addr & ~32'h7);
                        reply_due_q.push_back(cycle + 1 + int'($urandom % 6));
                    end
                    next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                end
                mem2cache_tag  <= '0;
                mem2cache_data <= '0;
                reply_idx = -1;
                foreach (reply_due_q[i]) begin
                    if (reply_idx < 0 && reply_due_q[i] <= cycle)
                        reply_idx = i;
                end
                if (reply_idx >= 0) begin   // One reply per cycle
                    mem2cache_tag  <= reply_tag_q[reply_idx];
                    mem2cache_data <= block_data(reply_addr_q[reply_idx]);
                    reply_tag_q.delete(reply_idx);
                    reply_addr_q.delete(reply_idx);
                    reply_due_q.delete(reply_idx);
                end
                // Offer the tag of the next request, or refuse
                if ($urandom % 3 != 0)
                    mem2cache_response <= (mem2cache_response != '0 &&
                        cache2mem_command != bus_none) ?
                        ((next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1) : next_tag;
                else
                    mem2cache_response <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks and waits
    ////////////////////////////////////////////////////////////

    function automatic logic [inst_w-1:0] expected_word(input logic [xlen-1:0] fetch);
        logic [xlen-1:0] block;
        block = fetch & ~32'h7;
        return fetch[2] ? (block ^ 32'h5a5a5a5a) : block;
    endfunction

    task automatic add_entry(input logic [xlen-1:0] fetch, input bus_command_t cmd,
                             input logic [xlen-1:0] daddr, input logic hit);
        tests.push_back({fetch, cmd, daddr, expected_word(fetch), hit});
    endtask

    task automatic check_value(input string signal, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %h, got %h",
                     $time, signal, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s did not happen within %0d cycles",
                 $time, what, wait_limit);
        errors++;
        test_errors++;
    endtask

    // Memory port must show the held data request until accept
    task automatic wait_data_accept(input bus_command_t cmd, input logic [xlen-1:0] daddr,
                                    input mem_size_t size,
                                    input logic [mem_data_w-1:0] wdata,
                                    output logic [tag_w-1:0] tag);
        int count;
        count = 0;
        tag = '0;
        while (!mem2dcache_response_valid && count < wait_limit) begin
            check_value("cache2mem_command", 64'(cmd), 64'(cache2mem_command));
            check_value("cache2mem_addr", 64'(daddr), 64'(cache2mem_addr));
            check_value("cache2mem_size", 64'(size), 64'(cache2mem_size));
            check_value("cache2mem_data", wdata, cache2mem_data);
            @(negedge clock);
            count++;
        end
        if (mem2dcache_response_valid) begin
            check_value("mem2dcache_response", 64'(mem2cache_response),
                        64'(mem2dcache_response));
            tag = mem2cache_response;
        end else begin
            report_timeout("data request accept");
        end
    endtask

    task automatic wait_data_reply(input logic [tag_w-1:0] tag, input logic [xlen-1:0] daddr,
                                   input logic hit, input logic [inst_w-1:0] exp_word);
        int count;
        count = 0;
        @(negedge clock);
        while (mem2dcache_tag != tag && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (mem2dcache_tag != tag) begin
            report_timeout("data load reply");
        end else begin
            check_value("mem2dcache_data", block_data(daddr & ~32'h7), mem2dcache_data);
            if (hit)
                check_value("icache2proc_data", 64'(exp_word), 64'(icache2proc_data));
        end
    endtask

    task automatic wait_fetch_valid(input logic [inst_w-1:0] exp_word);
        int count;
        count = 0;
        @(negedge clock);
        while (!icache2proc_valid && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (icache2proc_valid)
            check_value("icache2proc_data", 64'(exp_word), 64'(icache2proc_data));
        else
            report_timeout("icache fill");
    endtask

    task automatic run_entry(input int num, input entry_t e);
        logic [tag_w-1:0]      tag;
        bus_command_t          cmd;
        mem_size_t             size;
        logic [mem_data_w-1:0] wdata;
        cmd = e.data_cmd;
        size = (cmd == bus_store) ? word_sz : double_sz;
        wdata = {e.data_addr, ~e.data_addr};
        test_errors = 0;
        @(posedge clock);
        proc2icache_addr   <= e.fetch_addr;
        dcache2mem_command <= cmd;
        dcache2mem_addr    <= e.data_addr;
        dcache2mem_size    <= size;
        dcache2mem_data    <= wdata;
        @(negedge clock);
        check_value("icache2proc_valid", 64'(e.exp_hit), 64'(icache2proc_valid));
        if (!e.exp_hit && cmd == bus_none) begin   // Miss goes straight out
            check_value("cache2mem_command", 64'(bus_load), 64'(cache2mem_command));
            check_value("cache2mem_addr", 64'(e.fetch_addr & ~32'h7), 64'(cache2mem_addr));
            check_value("cache2mem_size", 64'(double_sz), 64'(cache2mem_size));
            check_value("cache2mem_data", 64'h0, cache2mem_data);
        end
        if (cmd != bus_none) begin
            wait_data_accept(cmd, e.data_addr, size, wdata, tag);
            @(posedge clock);
            dcache2mem_command <= bus_none;
            if (cmd == bus_load && tag != '0)
                wait_data_reply(tag, e.data_addr, e.exp_hit, e.exp_word);
        end
        wait_fetch_valid(e.exp_word);
        if (test_errors != 0)
            tests_failed++;
        $display("test %0d fetch %h data %s %h: %s", num, e.fetch_addr, cmd.name(),
                 e.data_addr, (test_errors == 0) ? "pass" : "fail");
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n              = 1'b0;
        proc2icache_addr   = '0;
        dcache2mem_command = bus_none;
        dcache2mem_addr    = '0;
        dcache2mem_size    = double_sz;
        dcache2mem_data    = '0;

        add_entry(32'h0000_1000, bus_none,  32'h0,          1'b0);  // Cold miss
        add_entry(32'h0000_1004, bus_none,  32'h0,          1'b1);  // Other word
        add_entry(32'h0000_2010, bus_load,  32'h0000_8020,  1'b0);  // Load over miss
        add_entry(32'h0000_2014, bus_none,  32'h0,          1'b1);
        add_entry(32'h0000_1000, bus_load,  32'h0000_4048,  1'b1);  // Reply during hit
        add_entry(32'h0001_1004, bus_none,  32'h0,          1'b0);  // Same index, new tag
        add_entry(32'h0000_1000, bus_store, 32'h0000_0300,  1'b0);
        add_entry(32'h0001_1000, bus_none,  32'h0,          1'b0);

        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        foreach (tests[i])
            run_entry(i, tests[i]);

        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests.size(),
                 tests.size() - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : mem_system_tb

`default_nettype wire
